// File: common/commit_pkg.sv
package commit_pkg;

    // Datapath widths
    localparam int DATA_W = 32;  // Result word
    localparam int REG_W  = 5;   // Architectural register address
    localparam int TAG_W  = 6;   // ROB tag, upper half belongs to the LSU

    // Commit buffer geometry
    localparam int BUF_DEPTH = 4;
    localparam int PTR_W     = 2;  // BUF_DEPTH must stay a power of two

    // Channel indices
    localparam int CH_ITU = 0;  // Merged ITU/CSR channel
    localparam int CH_LSU = 1;  // Variable latency load/store channel

    localparam int N_FWD = 2;  // Register source ports served by forwarding

endpackage : commit_pkg

// File: rtl/result_merge.sv
`timescale 1ns/1ps

module result_merge (
    input  logic                                                clk_i,
    input  logic                                                rst_n_i,
    input  logic                                                itu_valid_i,
    input  logic [commit_pkg::DATA_W-1:0]                       itu_result_i,
    input  logic [commit_pkg::TAG_W-1:0]                        itu_tag_i,
    input  logic [commit_pkg::REG_W-1:0]                        itu_rd_i,
    input  logic                                                itu_exc_i,
    input  logic                                                csr_valid_i,
    input  logic [commit_pkg::DATA_W-1:0]                       csr_result_i,
    input  logic [commit_pkg::TAG_W-1:0]                        csr_tag_i,
    input  logic [commit_pkg::REG_W-1:0]                        csr_rd_i,
    input  logic                                                csr_exc_i,
    input  logic                                                lsu_valid_i,
    input  logic [commit_pkg::DATA_W-1:0]                       lsu_result_i,
    input  logic [commit_pkg::TAG_W-1:0]                        lsu_tag_i,
    input  logic [commit_pkg::REG_W-1:0]                        lsu_rd_i,
    input  logic                                                lsu_exc_i,
    input  logic [commit_pkg::N_FWD-1:0][commit_pkg::REG_W-1:0] fwd_src_i,
    output logic [1:0]                                          ch_valid_o,
    output logic [1:0][commit_pkg::DATA_W-1:0]                  ch_result_o,
    output logic [1:0][commit_pkg::TAG_W-1:0]                   ch_tag_o,
    output logic [1:0][commit_pkg::REG_W-1:0]                   ch_rd_o,
    output logic [1:0]                                          ch_exc_o,
    output logic [commit_pkg::N_FWD-1:0]                        fresh_hit_o,
    output logic [commit_pkg::N_FWD-1:0][commit_pkg::DATA_W-1:0] fresh_data_o,
    output logic [1:0][commit_pkg::REG_W-1:0]                   inv_rd_o
);

    // CSR and ITU share one channel, the CSR fields win when it is valid
    always_comb begin
        ch_valid_o[commit_pkg::CH_ITU]  = itu_valid_i | csr_valid_i;
        ch_result_o[commit_pkg::CH_ITU] = csr_valid_i ? csr_result_i : itu_result_i;
        ch_tag_o[commit_pkg::CH_ITU]    = csr_valid_i ? csr_tag_i : itu_tag_i;
        ch_rd_o[commit_pkg::CH_ITU]     = csr_valid_i ? csr_rd_i : itu_rd_i;
        ch_exc_o[commit_pkg::CH_ITU]    = csr_valid_i ? csr_exc_i : itu_exc_i;
        ch_valid_o[commit_pkg::CH_LSU]  = lsu_valid_i;  // LSU keeps its own lane
        ch_result_o[commit_pkg::CH_LSU] = lsu_result_i;
        ch_tag_o[commit_pkg::CH_LSU]    = lsu_tag_i;
        ch_rd_o[commit_pkg::CH_LSU]     = lsu_rd_i;
        ch_exc_o[commit_pkg::CH_LSU]    = lsu_exc_i;
    end

    // Indexed by receiving buffer, each gets the other lane's destination
    assign inv_rd_o[commit_pkg::CH_ITU] = ch_rd_o[commit_pkg::CH_LSU];
    assign inv_rd_o[commit_pkg::CH_LSU] = ch_rd_o[commit_pkg::CH_ITU];

    // Fresh result match per source port
    always_comb begin
        for (int p = 0; p < commit_pkg::N_FWD; p++) begin
            fresh_hit_o[p]  = 1'b0;
            fresh_data_o[p] = '0;
            for (int c = 0; c < 2; c++) begin
                if (ch_valid_o[c] && !ch_exc_o[c] && (ch_rd_o[c] == fwd_src_i[p])
                        && (fwd_src_i[p] != '0)) begin
                    fresh_hit_o[p]  = 1'b1;  // x0 and faulting results never match
                    fresh_data_o[p] = ch_result_o[c];
                end
            end
        end
    end

    // Upstream scheduling guarantees, checked at the merge point
    assert property (@(posedge clk_i) disable iff (!rst_n_i)
        $onehot0({itu_valid_i, csr_valid_i}))
        else $error("ITU and CSR finished in the same cycle");

    assert property (@(posedge clk_i) disable iff (!rst_n_i)
        (&ch_valid_o) |-> (ch_rd_o[commit_pkg::CH_ITU] != ch_rd_o[commit_pkg::CH_LSU])
                          || (ch_rd_o[commit_pkg::CH_ITU] == '0))
        else $error("Both channels write the same destination");

endmodule : result_merge

// File: commit_buffer/commit_buffer.sv
`timescale 1ns/1ps

module commit_buffer (
    input  logic                                                clk_i,
    input  logic                                                rst_n_i,
    input  logic                                                flush_i,
    input  logic                                                push_i,
    input  logic                                                pull_i,
    input  logic [commit_pkg::DATA_W-1:0]                       result_i,
    input  logic [commit_pkg::TAG_W-1:0]                        tag_i,
    input  logic [commit_pkg::REG_W-1:0]                        rd_i,
    input  logic                                                exc_i,
    input  logic                                                inv_en_i,
    input  logic [commit_pkg::REG_W-1:0]                        inv_rd_i,
    input  logic [commit_pkg::N_FWD-1:0][commit_pkg::REG_W-1:0] fwd_src_i,
    output logic [commit_pkg::DATA_W-1:0]                       head_result_o,
    output logic [commit_pkg::TAG_W-1:0]                        head_tag_o,
    output logic [commit_pkg::REG_W-1:0]                        head_rd_o,
    output logic                                                head_exc_o,
    output logic [commit_pkg::N_FWD-1:0]                        fwd_hit_o,
    output logic [commit_pkg::N_FWD-1:0][commit_pkg::DATA_W-1:0] fwd_data_o,
    output logic                                                full_o,
    output logic                                                empty_o
);

    // Entry storage
    logic [commit_pkg::DATA_W-1:0]    result_q [commit_pkg::BUF_DEPTH];
    logic [commit_pkg::TAG_W-1:0]     tag_q    [commit_pkg::BUF_DEPTH];
    logic [commit_pkg::REG_W-1:0]     rd_q     [commit_pkg::BUF_DEPTH];
    logic [commit_pkg::BUF_DEPTH-1:0] exc_q;
    logic [commit_pkg::BUF_DEPTH-1:0] fwd_vld_q;  // Entry may still forward

    // Ring control
    logic [commit_pkg::PTR_W-1:0] wr_ptr_q, rd_ptr_q;
    logic [commit_pkg::PTR_W:0]   count_q;  // One bit wider than the pointers

    always_ff @(posedge clk_i) begin
        if (push_i) begin
            result_q[wr_ptr_q] <= result_i;
            tag_q[wr_ptr_q]    <= tag_i;
            rd_q[wr_ptr_q]     <= rd_i;
            exc_q[wr_ptr_q]    <= exc_i;
        end
    end

    always_ff @(posedge clk_i) begin
        if (!rst_n_i || flush_i) begin
            wr_ptr_q  <= '0;
            rd_ptr_q  <= '0;
            count_q   <= '0;
            fwd_vld_q <= '0;
        end else begin
            for (int i = 0; i < commit_pkg::BUF_DEPTH; i++) begin
                // Stale once a newer write of the register arrives on either lane
                if ((inv_en_i && (rd_q[i] == inv_rd_i)) || (push_i && (rd_q[i] == rd_i))
                        || (pull_i && (rd_ptr_q == commit_pkg::PTR_W'(i)))) begin
                    fwd_vld_q[i] <= 1'b0;
                end
            end
            if (push_i) begin
                fwd_vld_q[wr_ptr_q] <= !exc_i && (rd_i != '0);  // Overrides the clear above
                wr_ptr_q            <= wr_ptr_q + 1'b1;
            end
            if (pull_i) begin
                rd_ptr_q <= rd_ptr_q + 1'b1;
            end
            case ({push_i, pull_i})
                2'b10:   count_q <= count_q + 1'b1;
                2'b01:   count_q <= count_q - 1'b1;
                default: ;  // Both or neither keep the level
            endcase
        end
    end

    assign head_result_o = result_q[rd_ptr_q];
    assign head_tag_o    = tag_q[rd_ptr_q];
    assign head_rd_o     = rd_q[rd_ptr_q];
    assign head_exc_o    = exc_q[rd_ptr_q];

    assign full_o  = count_q[commit_pkg::PTR_W];  // MSB set means BUF_DEPTH entries
    assign empty_o = (count_q == '0);

    // At most one live copy per register, so the search needs no priority
    always_comb begin
        for (int p = 0; p < commit_pkg::N_FWD; p++) begin
            fwd_hit_o[p]  = 1'b0;
            fwd_data_o[p] = '0;
            for (int i = 0; i < commit_pkg::BUF_DEPTH; i++) begin
                if (fwd_vld_q[i] && (rd_q[i] == fwd_src_i[p])) begin
                    fwd_hit_o[p]  = 1'b1;
                    fwd_data_o[p] = result_q[i];
                end
            end
        end
    end

    // Arbiter side must respect the occupancy
    assert property (@(posedge clk_i) disable iff (!rst_n_i)
        (full_o && push_i) |-> pull_i)
        else $error("Push into a full commit buffer");

    assert property (@(posedge clk_i) disable iff (!rst_n_i)
        empty_o |-> !pull_i)
        else $error("Pull from an empty commit buffer");

endmodule : commit_buffer

// File: rtl/commit_arbiter.sv
`timescale 1ns/1ps

module commit_arbiter (
    input  logic                                                   clk_i,
    input  logic                                                   rst_n_i,
    input  logic [1:0]                                             ch_valid_i,
    input  logic [1:0][commit_pkg::DATA_W-1:0]                     ch_result_i,
    input  logic [1:0][commit_pkg::TAG_W-1:0]                      ch_tag_i,
    input  logic [1:0][commit_pkg::REG_W-1:0]                      ch_rd_i,
    input  logic [1:0]                                             ch_exc_i,
    input  logic [1:0][commit_pkg::DATA_W-1:0]                     head_result_i,
    input  logic [1:0][commit_pkg::TAG_W-1:0]                      head_tag_i,
    input  logic [1:0][commit_pkg::REG_W-1:0]                      head_rd_i,
    input  logic [1:0]                                             head_exc_i,
    input  logic [1:0]                                             empty_i,
    input  logic [1:0]                                             full_i,
    input  logic [commit_pkg::N_FWD-1:0]                           fresh_hit_i,
    input  logic [commit_pkg::N_FWD-1:0][commit_pkg::DATA_W-1:0]   fresh_data_i,
    input  logic [1:0][commit_pkg::N_FWD-1:0]                      buf_fwd_hit_i,
    input  logic [1:0][commit_pkg::N_FWD-1:0][commit_pkg::DATA_W-1:0] buf_fwd_data_i,
    output logic [1:0]                                             push_o,
    output logic [1:0]                                             pull_o,
    output logic                                                   rob_write_o,
    output logic [commit_pkg::TAG_W-1:0]                           rob_tag_o,
    output logic [commit_pkg::DATA_W-1:0]                          rob_result_o,
    output logic [commit_pkg::REG_W-1:0]                           rob_rd_o,
    output logic                                                   rob_exc_o,
    output logic [commit_pkg::N_FWD-1:0][commit_pkg::DATA_W-1:0]   fwd_data_o,
    output logic [commit_pkg::N_FWD-1:0]                           fwd_valid_o,
    output logic                                                   stall_o
);

    logic srv_q, srv_d;  // Channel whose turn it is
    logic oth;

    assign oth = ~srv_q;

    always_ff @(posedge clk_i) begin
        if (!rst_n_i) begin
            srv_q <= 1'(commit_pkg::CH_ITU);
        end else begin
            srv_q <= srv_d;
        end
    end

    // Hand the turn over as soon as the other lane has work queued
    assign srv_d = empty_i[oth] ? srv_q : oth;

    always_comb begin
        push_o       = '0;
        pull_o       = '0;
        rob_write_o  = 1'b0;
        rob_tag_o    = ch_tag_i[srv_q];  // Bypass fields by default
        rob_result_o = ch_result_i[srv_q];
        rob_rd_o     = ch_rd_i[srv_q];
        rob_exc_o    = ch_exc_i[srv_q];
        if (!empty_i[srv_q]) begin
            pull_o[srv_q] = 1'b1;  // Oldest entry commits first
            push_o[srv_q] = ch_valid_i[srv_q];  // Newcomer queues behind it
            rob_write_o   = 1'b1;
            rob_tag_o     = head_tag_i[srv_q];
            rob_result_o  = head_result_i[srv_q];
            rob_rd_o      = head_rd_i[srv_q];
            rob_exc_o     = head_exc_i[srv_q];
        end else begin
            rob_write_o = ch_valid_i[srv_q];  // Empty buffer, straight to the ROB
        end
        push_o[oth] = ch_valid_i[oth];  // Waiting lane always buffers
    end

    assign stall_o = |full_i;

    // Fresh result first, then whichever buffer still holds a live copy
    always_comb begin
        for (int p = 0; p < commit_pkg::N_FWD; p++) begin
            fwd_valid_o[p] = fresh_hit_i[p] | buf_fwd_hit_i[commit_pkg::CH_ITU][p]
                           | buf_fwd_hit_i[commit_pkg::CH_LSU][p];
            if (fresh_hit_i[p]) begin
                fwd_data_o[p] = fresh_data_i[p];
            end else if (buf_fwd_hit_i[commit_pkg::CH_ITU][p]) begin
                fwd_data_o[p] = buf_fwd_data_i[commit_pkg::CH_ITU][p];
            end else begin
                fwd_data_o[p] = buf_fwd_data_i[commit_pkg::CH_LSU][p];
            end
        end
    end

    // Units upstream hold off while any buffer is full
    assert property (@(posedge clk_i) disable iff (!rst_n_i)
        stall_o |-> (ch_valid_i == '0))
        else $error("Result presented during stall");

endmodule : commit_arbiter

// File: rtl/commit_stage.sv
`timescale 1ns/1ps

module commit_stage (
    input  logic                                                 clk_i,
    input  logic                                                 rst_n_i,
    input  logic                                                 flush_i,
    input  logic                                                 itu_valid_i,
    input  logic [commit_pkg::DATA_W-1:0]                        itu_result_i,
    input  logic [commit_pkg::TAG_W-1:0]                         itu_tag_i,
    input  logic [commit_pkg::REG_W-1:0]                         itu_rd_i,
    input  logic                                                 itu_exc_i,
    input  logic                                                 csr_valid_i,
    input  logic [commit_pkg::DATA_W-1:0]                        csr_result_i,
    input  logic [commit_pkg::TAG_W-1:0]                         csr_tag_i,
    input  logic [commit_pkg::REG_W-1:0]                         csr_rd_i,
    input  logic                                                 csr_exc_i,
    input  logic                                                 lsu_valid_i,
    input  logic [commit_pkg::DATA_W-1:0]                        lsu_result_i,
    input  logic [commit_pkg::TAG_W-1:0]                         lsu_tag_i,
    input  logic [commit_pkg::REG_W-1:0]                         lsu_rd_i,
    input  logic                                                 lsu_exc_i,
    input  logic [commit_pkg::N_FWD-1:0][commit_pkg::REG_W-1:0]  fwd_src_i,
    output logic                                                 rob_write_o,
    output logic [commit_pkg::TAG_W-1:0]                         rob_tag_o,
    output logic [commit_pkg::DATA_W-1:0]                        rob_result_o,
    output logic [commit_pkg::REG_W-1:0]                         rob_rd_o,
    output logic                                                 rob_exc_o,
    output logic [commit_pkg::N_FWD-1:0][commit_pkg::DATA_W-1:0] fwd_data_o,
    output logic [commit_pkg::N_FWD-1:0]                         fwd_valid_o,
    output logic                                                 stall_o
);

    // Channel write buses, indexed by CH_ITU / CH_LSU
    logic [1:0]                         ch_valid, ch_exc;
    logic [1:0][commit_pkg::DATA_W-1:0] ch_result;
    logic [1:0][commit_pkg::TAG_W-1:0]  ch_tag;
    logic [1:0][commit_pkg::REG_W-1:0]  ch_rd, inv_rd;

    // Buffer heads and status
    logic [1:0]                         head_exc, full, empty, push, pull;
    logic [1:0][commit_pkg::DATA_W-1:0] head_result;
    logic [1:0][commit_pkg::TAG_W-1:0]  head_tag;
    logic [1:0][commit_pkg::REG_W-1:0]  head_rd;

    // Forwarding
    logic [commit_pkg::N_FWD-1:0]                          fresh_hit;
    logic [commit_pkg::N_FWD-1:0][commit_pkg::DATA_W-1:0]  fresh_data;
    logic [1:0][commit_pkg::N_FWD-1:0]                     buf_fwd_hit;
    logic [1:0][commit_pkg::N_FWD-1:0][commit_pkg::DATA_W-1:0] buf_fwd_data;

    result_merge u_merge (
        .clk_i        (clk_i),        .rst_n_i      (rst_n_i),
        .itu_valid_i  (itu_valid_i),  .itu_result_i (itu_result_i), .itu_tag_i (itu_tag_i),
        .itu_rd_i     (itu_rd_i),     .itu_exc_i    (itu_exc_i),
        .csr_valid_i  (csr_valid_i),  .csr_result_i (csr_result_i), .csr_tag_i (csr_tag_i),
        .csr_rd_i     (csr_rd_i),     .csr_exc_i    (csr_exc_i),
        .lsu_valid_i  (lsu_valid_i),  .lsu_result_i (lsu_result_i), .lsu_tag_i (lsu_tag_i),
        .lsu_rd_i     (lsu_rd_i),     .lsu_exc_i    (lsu_exc_i),
        .fwd_src_i    (fwd_src_i),
        .ch_valid_o   (ch_valid),     .ch_result_o  (ch_result),    .ch_tag_o  (ch_tag),
        .ch_rd_o      (ch_rd),        .ch_exc_o     (ch_exc),
        .fresh_hit_o  (fresh_hit),    .fresh_data_o (fresh_data),   .inv_rd_o  (inv_rd)
    );

    // Each buffer drops its copies when the other lane pushes the same register
    commit_buffer itu_buffer (
        .clk_i         (clk_i),        .rst_n_i     (rst_n_i),      .flush_i (flush_i),
        .push_i        (push[commit_pkg::CH_ITU]),
        .pull_i        (pull[commit_pkg::CH_ITU]),
        .result_i      (ch_result[commit_pkg::CH_ITU]),
        .tag_i         (ch_tag[commit_pkg::CH_ITU]),
        .rd_i          (ch_rd[commit_pkg::CH_ITU]),
        .exc_i         (ch_exc[commit_pkg::CH_ITU]),
        .inv_en_i      (push[commit_pkg::CH_LSU]),
        .inv_rd_i      (inv_rd[commit_pkg::CH_ITU]),
        .fwd_src_i     (fwd_src_i),
        .head_result_o (head_result[commit_pkg::CH_ITU]),
        .head_tag_o    (head_tag[commit_pkg::CH_ITU]),
        .head_rd_o     (head_rd[commit_pkg::CH_ITU]),
        .head_exc_o    (head_exc[commit_pkg::CH_ITU]),
        .fwd_hit_o     (buf_fwd_hit[commit_pkg::CH_ITU]),
        .fwd_data_o    (buf_fwd_data[commit_pkg::CH_ITU]),
        .full_o        (full[commit_pkg::CH_ITU]),
        .empty_o       (empty[commit_pkg::CH_ITU])
    );

    commit_buffer lsu_buffer (
        .clk_i         (clk_i),        .rst_n_i     (rst_n_i),      .flush_i (flush_i),
        .push_i        (push[commit_pkg::CH_LSU]),
        .pull_i        (pull[commit_pkg::CH_LSU]),
        .result_i      (ch_result[commit_pkg::CH_LSU]),
        .tag_i         (ch_tag[commit_pkg::CH_LSU]),
        .rd_i          (ch_rd[commit_pkg::CH_LSU]),
        .exc_i         (ch_exc[commit_pkg::CH_LSU]),
        .inv_en_i      (push[commit_pkg::CH_ITU]),
        .inv_rd_i      (inv_rd[commit_pkg::CH_LSU]),
        .fwd_src_i     (fwd_src_i),
        .head_result_o (head_result[commit_pkg::CH_LSU]),
        .head_tag_o    (head_tag[commit_pkg::CH_LSU]),
        .head_rd_o     (head_rd[commit_pkg::CH_LSU]),
        .head_exc_o    (head_exc[commit_pkg::CH_LSU]),
        .fwd_hit_o     (buf_fwd_hit[commit_pkg::CH_LSU]),
        .fwd_data_o    (buf_fwd_data[commit_pkg::CH_LSU]),
        .full_o        (full[commit_pkg::CH_LSU]),
        .empty_o       (empty[commit_pkg::CH_LSU])
    );

    commit_arbiter u_arbiter (
        .clk_i          (clk_i),       .rst_n_i       (rst_n_i),
        .ch_valid_i     (ch_valid),    .ch_result_i   (ch_result),   .ch_tag_i   (ch_tag),
        .ch_rd_i        (ch_rd),       .ch_exc_i      (ch_exc),
        .head_result_i  (head_result), .head_tag_i    (head_tag),    .head_rd_i  (head_rd),
        .head_exc_i     (head_exc),    .empty_i       (empty),       .full_i     (full),
        .fresh_hit_i    (fresh_hit),   .fresh_data_i  (fresh_data),
        .buf_fwd_hit_i  (buf_fwd_hit), .buf_fwd_data_i (buf_fwd_data),
        .push_o         (push),        .pull_o        (pull),
        .rob_write_o    (rob_write_o), .rob_tag_o     (rob_tag_o),   .rob_result_o (rob_result_o),
        .rob_rd_o       (rob_rd_o),    .rob_exc_o     (rob_exc_o),
        .fwd_data_o     (fwd_data_o),  .fwd_valid_o   (fwd_valid_o), .stall_o    (stall_o)
    );

endmodule : commit_stage

// File: sim/commit_vectors.svh
// Columns: ch0 valid (1 ITU, 2 CSR), lsu valid, ch0 tag, lsu tag, ch0 rd, lsu rd,
// ch0 exc, lsu exc, flush, src0, src1, expected fwd0, expected fwd1, last row of test
// Bypass of a lone ITU and a lone CSR result
add_row(0, 0,  0,  0,  0,  0, 0, 0, 0,  0,  0, NO_FWD,    NO_FWD,    0);
add_row(1, 0,  1,  0,  3,  0, 0, 0, 0,  3,  0, fw(0, 1),  NO_FWD,    0);
add_row(2, 0,  2,  0,  4,  0, 0, 0, 0,  4,  3, fw(0, 2),  NO_FWD,    0);
add_row(0, 0,  0,  0,  0,  0, 0, 0, 0,  4,  0, NO_FWD,    NO_FWD,    1);
// Both lanes streaming, LSU buffer fills and stalls
add_row(1, 1,  3, 32,  5,  6, 0, 0, 0,  6,  5, fw(1, 4),  fw(0, 4),  0);
add_row(1, 1,  4, 33,  7,  8, 0, 0, 0,  6,  8, fw(1, 4),  fw(1, 5),  0);
add_row(1, 1,  5, 34,  9, 10, 0, 0, 0,  6,  9, fw(1, 4),  fw(0, 6),  0);
add_row(1, 1,  6, 35, 11, 12, 0, 0, 0,  9, 10, fw(0, 6),  fw(1, 6),  0);
add_row(1, 1,  7, 36, 13, 14, 0, 0, 0, 11, 12, fw(0, 7),  fw(1, 7),  0);
add_row(1, 1,  8, 37, 15, 16, 0, 0, 0, 13, 14, fw(0, 8),  fw(1, 8),  0);
add_row(1, 1,  9, 38, 17, 18, 0, 0, 0, 15, 16, fw(0, 9),  fw(1, 9),  0);
add_row(1, 1, 10, 39, 19, 20, 0, 0, 0, 17, 18, fw(0, 10), fw(1, 10), 1);
// Fresh against buffered, x0 and faulting results
add_row(1, 0, 11,  0,  3,  0, 0, 0, 0,  3,  0, fw(0, 12), NO_FWD,    0);
add_row(0, 1,  0, 40,  0,  0, 0, 0, 0,  3,  0, fw(0, 12), NO_FWD,    0);
add_row(1, 0, 12,  0,  5,  0, 1, 0, 0,  5,  3, NO_FWD,    fw(0, 12), 0);
add_row(0, 0,  0,  0,  0,  0, 0, 0, 0,  5,  3, NO_FWD,    NO_FWD,    1);
// Cross lane and same lane invalidation
add_row(0, 1,  0, 41,  0, 21, 0, 0, 0, 21,  0, fw(1, 16), NO_FWD,    0);
add_row(1, 0, 13,  0, 20,  0, 0, 0, 0, 21, 20, fw(1, 16), fw(0, 17), 0);
add_row(1, 0, 14,  0,  9,  0, 0, 0, 0,  9, 21, fw(0, 18), fw(1, 16), 0);
add_row(1, 0, 15,  0,  7,  0, 0, 0, 0,  9,  7, fw(0, 18), fw(0, 19), 0);
add_row(0, 1,  0, 42,  0,  7, 0, 0, 0,  7,  9, fw(1, 20), fw(0, 18), 0);
add_row(0, 0,  0,  0,  0,  0, 0, 0, 0,  7,  9, fw(1, 20), NO_FWD,    0);
add_row(1, 0, 16,  0, 11,  0, 0, 0, 0,  7, 11, fw(1, 20), fw(0, 22), 0);
add_row(1, 0, 17,  0, 11,  0, 1, 0, 0, 11,  7, fw(0, 22), NO_FWD,    0);
add_row(0, 0,  0,  0,  0,  0, 0, 0, 0, 11,  0, NO_FWD,    NO_FWD,    0);
add_row(0, 0,  0,  0,  0,  0, 0, 0, 0, 11,  0, NO_FWD,    NO_FWD,    1);
// Flush with both buffers holding entries
add_row(1, 1, 18, 44, 12, 13, 0, 0, 0, 13, 12, fw(1, 26), fw(0, 26), 0);
add_row(1, 1, 19, 45, 14, 15, 0, 0, 0, 13, 15, fw(1, 26), fw(1, 27), 0);
add_row(1, 1, 20, 46, 16, 17, 0, 0, 0, 15, 16, fw(1, 27), fw(0, 28), 0);
add_row(0, 0,  0,  0,  0,  0, 0, 0, 1, 17, 16, fw(1, 28), fw(0, 28), 0);
add_row(0, 0,  0,  0,  0,  0, 0, 0, 0, 17, 16, NO_FWD,    NO_FWD,    0);
add_row(1, 0, 21,  0, 18,  0, 0, 0, 0, 18,  0, fw(0, 31), NO_FWD,    1);

// File: sim/tb_commit_stage.sv
`timescale 1ns/1ps

module tb_commit_stage;

    localparam int SEED       = 58808;
    localparam int MAX_ROWS   = 64;
    localparam int WAIT_LIMIT = 40;  // Cycles per wait loop
    localparam int NO_FWD     = 255;
    localparam int DW = commit_pkg::DATA_W;
    localparam int TW = commit_pkg::TAG_W;
    localparam int RW = commit_pkg::REG_W;
    localparam int EW = TW + RW + 1 + DW;  // Scoreboard entry, tag rd exc result

    logic clk_i, rst_n_i, flush_i;
    logic itu_valid_i, csr_valid_i, lsu_valid_i;
    logic itu_exc_i, csr_exc_i, lsu_exc_i;
    logic [DW-1:0] itu_result_i, csr_result_i, lsu_result_i;
    logic [TW-1:0] itu_tag_i, csr_tag_i, lsu_tag_i;
    logic [RW-1:0] itu_rd_i, csr_rd_i, lsu_rd_i;
    logic [1:0][RW-1:0] fwd_src_i;
    logic rob_write_o, rob_exc_o, stall_o;
    logic [TW-1:0] rob_tag_o;
    logic [DW-1:0] rob_result_o;
    logic [RW-1:0] rob_rd_o;
    logic [1:0][DW-1:0] fwd_data_o;
    logic [1:0] fwd_valid_o;

    // Stimulus table, one entry per column of the vector file
    int row_u0 [MAX_ROWS], row_u1 [MAX_ROWS], row_t0 [MAX_ROWS], row_t1 [MAX_ROWS];
    int row_d0 [MAX_ROWS], row_d1 [MAX_ROWS], row_e0 [MAX_ROWS], row_e1 [MAX_ROWS];
    int row_fl [MAX_ROWS], row_s0 [MAX_ROWS], row_s1 [MAX_ROWS];
    int row_x0 [MAX_ROWS], row_x1 [MAX_ROWS], row_last [MAX_ROWS];
    logic [DW-1:0] res0 [MAX_ROWS], res1 [MAX_ROWS];  // Random words per row
    int n_rows;

    logic [EW-1:0] q_itu [$], q_lsu [$];  // Pending commits per lane
    logic turn;  // Expected lane with the turn
    int checks, errors, inputs, writes, flushed;
    string test_name [5] = '{"bypass", "ordering", "forwarding", "invalidation", "flush"};

    commit_stage dut (.*);

    function automatic int fw(input int ch, input int row);
        return ch * 128 + row;
    endfunction

    task automatic add_row(input int u0, u1, t0, t1, d0, d1, e0, e1, fl, s0, s1, x0, x1,
                           input int last);
        row_u0[n_rows] = u0;
        row_u1[n_rows] = u1;
        row_t0[n_rows] = t0;
        row_t1[n_rows] = t1;
        row_d0[n_rows] = d0;
        row_d1[n_rows] = d1;
        row_e0[n_rows] = e0;
        row_e1[n_rows] = e1;
        row_fl[n_rows] = fl;
        row_s0[n_rows] = s0;
        row_s1[n_rows] = s1;
        row_x0[n_rows] = x0;
        row_x1[n_rows] = x1;
        row_last[n_rows] = last;
        n_rows++;
    endtask

    task automatic load_vectors();
        `include "commit_vectors.svh"
    endtask

    task automatic check(input string name, input logic [63:0] got, input logic [63:0] exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("Error: %s got %h expected %h", name, got, exp);
        end
    endtask

    task automatic drive_idle();
        itu_valid_i <= 1'b0;
        csr_valid_i <= 1'b0;
        lsu_valid_i <= 1'b0;
        flush_i     <= 1'b0;
    endtask

    task automatic drive_row(input int r);
        logic          sel_csr;
        logic [TW-1:0] tag0;
        logic [RW-1:0] rd0;
        logic          exc0;
        sel_csr = (row_u0[r] == 2);
        tag0    = TW'(row_t0[r]);
        rd0     = RW'(row_d0[r]);
        exc0    = (row_e0[r] != 0);
        res0[r] = $urandom;
        res1[r] = $urandom;
        itu_valid_i  <= (row_u0[r] == 1);
        csr_valid_i  <= sel_csr;
        lsu_valid_i  <= (row_u1[r] != 0);
        // Idle unit of the merged lane carries inverted fields
        itu_result_i <= sel_csr ? ~res0[r] : res0[r];
        csr_result_i <= sel_csr ? res0[r] : ~res0[r];
        lsu_result_i <= res1[r];
        itu_tag_i    <= sel_csr ? ~tag0 : tag0;
        csr_tag_i    <= sel_csr ? tag0 : ~tag0;
        lsu_tag_i    <= TW'(row_t1[r]);
        itu_rd_i     <= sel_csr ? ~rd0 : rd0;
        csr_rd_i     <= sel_csr ? rd0 : ~rd0;
        lsu_rd_i     <= RW'(row_d1[r]);
        itu_exc_i    <= exc0 ^ sel_csr;
        csr_exc_i    <= exc0 ^ !sel_csr;
        lsu_exc_i    <= (row_e1[r] != 0);
        flush_i      <= (row_fl[r] != 0);
        fwd_src_i[0] <= RW'(row_s0[r]);
        fwd_src_i[1] <= RW'(row_s1[r]);
    endtask

    // Per-cycle lane model, run while outputs are stable
    task automatic model_cycle();
        int sz0, sz1, ch;
        logic v0, exp_write, popped;
        logic [EW-1:0] head;
        v0  = itu_valid_i | csr_valid_i;
        sz0 = q_itu.size();
        sz1 = q_lsu.size();
        popped = 1'b0;
        head = '0;
        check("stall_o", 64'(stall_o),
              64'((sz0 == commit_pkg::BUF_DEPTH) || (sz1 == commit_pkg::BUF_DEPTH)));
        exp_write = turn ? ((sz1 > 0) || lsu_valid_i) : ((sz0 > 0) || v0);
        if (v0) begin
            if (csr_valid_i) begin
                q_itu.push_back({csr_tag_i, csr_rd_i, csr_exc_i, csr_result_i});
            end else begin
                q_itu.push_back({itu_tag_i, itu_rd_i, itu_exc_i, itu_result_i});
            end
            inputs++;
        end
        if (lsu_valid_i) begin
            q_lsu.push_back({lsu_tag_i, lsu_rd_i, lsu_exc_i, lsu_result_i});
            inputs++;
        end
        check("rob_write_o", 64'(rob_write_o), 64'(exp_write));
        if (rob_write_o) begin
            writes++;
            ch = int'(rob_tag_o[TW-1]);  // Upper tag half is the LSU
            check("rob_channel", 64'(ch), 64'(turn));
            if (ch == 0 && q_itu.size() > 0) begin
                head = q_itu.pop_front();
                popped = 1'b1;
            end else if (ch == 1 && q_lsu.size() > 0) begin
                head = q_lsu.pop_front();
                popped = 1'b1;
            end
            if (popped) begin
                check("rob_tag_o", 64'(rob_tag_o), 64'(head[EW-1 -: TW]));
                check("rob_rd_o", 64'(rob_rd_o), 64'(head[DW+1 +: RW]));
                check("rob_exc_o", 64'(rob_exc_o), 64'(head[DW]));
                check("rob_result_o", 64'(rob_result_o), 64'(head[DW-1:0]));
            end else begin
                errors++;
                $display("ROB write with no pending result on lane %0d", ch);
            end
        end
        if (turn) begin
            turn = (sz0 > 0) ? 1'b0 : 1'b1;
        end else begin
            turn = (sz1 > 0) ? 1'b1 : 1'b0;
        end
        if (flush_i) begin
            flushed += q_itu.size() + q_lsu.size();
            q_itu.delete();
            q_lsu.delete();
        end
    endtask

    task automatic check_forward(input int r);
        int code;
        for (int p = 0; p < 2; p++) begin
            code = (p == 0) ? row_x0[r] : row_x1[r];
            if (code == NO_FWD) begin
                check($sformatf("fwd_valid_o[%0d]", p), 64'(fwd_valid_o[p]), 64'(0));
            end else begin
                check($sformatf("fwd_valid_o[%0d]", p), 64'(fwd_valid_o[p]), 64'(1));
                check($sformatf("fwd_data_o[%0d]", p), 64'(fwd_data_o[p]),
                      64'((code >= 128) ? res1[code - 128] : res0[code]));
            end
        end
    endtask

    initial begin
        clk_i = 1'b0;
        forever #10 clk_i = ~clk_i;
    end

    initial begin
        int r, wait_n, test_id, err_start;
        void'($urandom(SEED));
        rst_n_i = 1'b0;
        flush_i = 1'b0;
        {itu_valid_i, csr_valid_i, lsu_valid_i} = '0;
        {itu_exc_i, csr_exc_i, lsu_exc_i} = '0;
        {itu_result_i, csr_result_i, lsu_result_i} = '0;
        {itu_tag_i, csr_tag_i, lsu_tag_i} = '0;
        {itu_rd_i, csr_rd_i, lsu_rd_i} = '0;
        fwd_src_i = '0;
        {checks, errors, inputs, writes, flushed, n_rows} = '0;
        turn = 1'b0;  // ITU lane after reset
        load_vectors();
        repeat (5) @(posedge clk_i);
        rst_n_i <= 1'b1;
        r = 0;
        test_id = 0;
        err_start = 0;
        wait_n = 0;
        while (r < n_rows) begin
            @(posedge clk_i);
            if (q_itu.size() == commit_pkg::BUF_DEPTH || q_lsu.size() == commit_pkg::BUF_DEPTH) begin
                drive_idle();  // Row held back while the stage stalls
                @(negedge clk_i);
                model_cycle();
                wait_n++;
                if (wait_n > WAIT_LIMIT) begin
                    $display("Timeout waiting for the stall to drop");
                    $display("*** FAILED ***");
                    $finish;
                end
            end else begin
                wait_n = 0;
                drive_row(r);
                @(negedge clk_i);
                model_cycle();
                check_forward(r);
                if (row_last[r] != 0) begin
                    while (q_itu.size() + q_lsu.size() > 0) begin
                        @(posedge clk_i);
                        drive_idle();
                        @(negedge clk_i);
                        model_cycle();
                        wait_n++;
                        if (wait_n > WAIT_LIMIT) begin
                            $display("Timeout while draining the commit buffers");
                            $display("*** FAILED ***");
                            $finish;
                        end
                    end
                    wait_n = 0;
                    $display("Test %0d %s: %0d errors", test_id, test_name[test_id],
                             errors - err_start);
                    err_start = errors;
                    test_id++;
                end
                r++;
            end
        end
        check("rob_writes", 64'(writes), 64'(inputs - flushed));
        $display("Checks %0d, errors %0d, inputs %0d, ROB writes %0d, flushed %0d",
                 checks, errors, inputs, writes, flushed);
        if (errors == 0) begin
            $display("*** PASSED ***");
        end else begin
            $display("*** FAILED ***");
        end
        $finish;
    end

endmodule : tb_commit_stage

// File: verilog.f
+incdir+sim
common/commit_pkg.sv
rtl/result_merge.sv
commit_buffer/commit_buffer.sv
rtl/commit_arbiter.sv
rtl/commit_stage.sv
sim/tb_commit_stage.sv

// File: run.sh
#!/usr/bin/env bash
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -f verilog.f --top-module tb_commit_stage \
    -Mdir obj_dir -o sim_commit_stage
./obj_dir/sim_commit_stage > sim.log 2>&1 || true
cat sim.log

if grep -q "\*\*\* PASSED \*\*\*" sim.log; then
    exit 0
else
    exit 1
fi
